//--- verif/al_load_tests.txt
# Columns: command letter, then its argument(s)
# C <hex word> <0 now | 1 once shifting runs>, R <hex word>, W <words>, X, E <0|1>
# Single word
C a5c3 0
W 1
X
# Back to back burst, capture order kept
C 0001 0
C 8000 0
C 1234 0
W 3
X
# Word appended while the first one shifts
C beef 0
C 5a5a 1
W 2
X
# New run after clearing done
C ffff 0
W 1
X
C 0f0f 0
W 1
X
# Capture lost to the slow FIFO reset
E 0
R dead
E 1
C 7e81 0
W 1
X
E 1
# Longer burst with a late append
C 3c3c 0
C c3c3 0
C 0100 0
C 8421 1
W 4
X

//--- build.f
src/bky_load_pkg.sv
src/shift_tick_timer.sv
src/bky_load_fsm.sv
src/al_word_fifo.sv
src/bky_shift_reg.sv
src/al_buckeye_load.sv
verif/tb_al_buckeye_load.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile with Verilator and run the testbench from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f \
	--top-module tb_al_buckeye_load || exit 1

out=$(./obj_dir/Vtb_al_buckeye_load)
echo "$out"

echo "$out" | grep -qx "Test passed" && exit 0 || exit 1

//--- verif/tb_al_buckeye_load.sv
module tb_al_buckeye_load import bky_load_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	logic              CLK40;
	logic              RST;
	logic              slow_fifo_rst;
	logic              clr_al_done;
	logic              capture;
	logic [word_w-1:0] bpi_al_reg;
	logic              al_bky_ena;
	logic              shck_ena;
	logic              sclk;
	logic              sdata;
	logic              al_done;
	logic              al_bk_ld_mt;
	logic              wrt_on_rst;
	bky_state_t        al_bk_state;

	logic [word_w-1:0] exp_q[$];          // Words the DUT still owes
	logic [word_w-1:0] got_q[$];          // Words rebuilt from sdata
	logic [word_w-1:0] shreg = '0;
	int                nbits = 0;
	logic              sclk_prev = 1'b0;
	int                n_tests = 0;
	int                n_errors = 0;
	logic              aborted = 1'b0;    // Stops the command loop

	al_buckeye_load dut0 (.*);

	initial begin
		CLK40 = 1'b0;
		forever #10 CLK40 = ~CLK40;
	end

	////////////////////////////////////////////////////////////
	// Serial word collector, one bit per sclk rising edge
	////////////////////////////////////////////////////////////
	always @(posedge CLK40) begin
		if (sclk && !sclk_prev && shck_ena) begin
			check_value(32'(al_bk_state), 32'(shift), "state while shifting");
			shreg = {sdata, shreg[word_w-1:1]}; // LSB arrives first
			nbits = nbits + 1;
			if (nbits == word_w) begin
				got_q.push_back(shreg);
				nbits = 0;
			end
		end
		sclk_prev = sclk;
	end

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		if (actual !== expected) begin
			$display("MISMATCH at %0t: %s got %h expected %h", $time, what, actual, expected);
			n_errors++;
		end
	endtask

	task automatic finish_test(input string name, input int errs_before);
		n_tests++;
		$display("%-28s %s", name, (n_errors == errs_before) ? "ok" : "FAILED");
	endtask

	task automatic skip_line(input int fd);
		int ch;
		ch = $fgetc(fd);
		while (ch != 10 && ch != -1)
			ch = $fgetc(fd);
	endtask

	task automatic capture_word(input logic [word_w-1:0] word, input logic during_rst);
		@(posedge CLK40);
		capture       <= 1'b1;
		bpi_al_reg    <= word;
		slow_fifo_rst <= during_rst;
		@(posedge CLK40);
		capture       <= 1'b0;
		slow_fifo_rst <= 1'b0;
	endtask

	task automatic wait_for_shifting();
		int cyc;
		cyc = 0;
		while (!shck_ena && cyc < 2000) begin
			@(negedge CLK40);
			cyc++;
		end
		if (!shck_ena) begin
			$display("Timeout: shifting did not start within 2000 cycles");
			n_errors++;
			aborted = 1'b1;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Run completion and word compare
	////////////////////////////////////////////////////////////
	task automatic wait_words(input int n);
		int cyc;
		int limit;
		int i;
		logic [word_w-1:0] want;
		cyc = 0;
		limit = 2000 * n;
		while (!(al_done && got_q.size() >= n) && cyc < limit) begin
			@(negedge CLK40);
			cyc++;
			if (al_done && got_q.size() < n) begin
				$display("Done rose at %0t after only %0d of %0d words", $time, got_q.size(), n);
				n_errors++;
				break;
			end
		end
		if (!al_done) begin
			$display("Timeout: %0d words and done not seen within %0d cycles", n, limit);
			n_errors++;
			aborted = 1'b1;
		end else begin
			for (i = 0; i < n; i++) begin
				if (got_q.size() == 0 || exp_q.size() == 0) begin
					$display("Serial word %0d of %0d is missing", i + 1, n);
					n_errors++;
				end else begin
					want = exp_q.pop_front();
					check_value(32'(got_q.pop_front()), 32'(want),
						$sformatf("serial word %0d", i + 1));
				end
			end
			check_value(32'(al_bk_ld_mt), 32'd1, "FIFO empty at done");
		end
	endtask

	task automatic clear_done();
		int cyc;
		cyc = 0;
		while (cyc < 100) begin // Done must hold with no clear
			@(negedge CLK40);
			check_value(32'(al_done), 32'd1, "done held before clear");
			cyc++;
		end
		@(posedge CLK40);
		clr_al_done <= 1'b1;
		@(posedge CLK40);
		clr_al_done <= 1'b0;
		@(negedge CLK40);
		check_value(32'(al_done), 32'd0, "done after clear");
		check_value(32'(al_bky_ena), 32'd0, "load flag after clear");
	endtask

	////////////////////////////////////////////////////////////
	// Command interpreter
	////////////////////////////////////////////////////////////
	initial begin
		int fd;
		int code;
		int n;
		int mode;
		int errs;
		logic [7:0] cmd;
		logic [word_w-1:0] word;
		RST           = 1'b1;
		slow_fifo_rst = 1'b0;
		clr_al_done   = 1'b0;
		capture       = 1'b0;
		bpi_al_reg    = '0;
		repeat (10) @(posedge CLK40);
		RST <= 1'b0;
		@(negedge CLK40);
		errs = n_errors;
		check_value(32'(al_done), 32'd0, "al_done after reset");
		check_value(32'(al_bky_ena), 32'd0, "al_bky_ena after reset");
		check_value(32'(shck_ena), 32'd0, "shck_ena after reset");
		check_value(32'(sclk), 32'd0, "sclk after reset");
		check_value(32'(sdata), 32'd0, "sdata after reset");
		check_value(32'(wrt_on_rst), 32'd0, "wrt_on_rst after reset");
		check_value(32'(al_bk_ld_mt), 32'd1, "al_bk_ld_mt after reset");
		check_value(32'(al_bk_state), 32'(idle), "al_bk_state after reset");
		finish_test("reset state", errs);
		fd = $fopen("verif/al_load_tests.txt", "r");
		if (fd == 0) begin
			$display("Could not open verif/al_load_tests.txt");
			n_errors++;
			aborted = 1'b1;
		end
		while (!aborted) begin
			code = $fscanf(fd, " %c", cmd);
			if (code != 1)
				break;
			errs = n_errors;
			case (cmd)
				"#": skip_line(fd);
				"C": begin
					code = $fscanf(fd, " %h %d", word, mode);
					if (mode != 0)
						wait_for_shifting(); // Append to a run in progress
					capture_word(word, 1'b0);
					exp_q.push_back(word);
				end
				"R": begin
					code = $fscanf(fd, " %h", word);
					capture_word(word, 1'b1);
				end
				"W": begin
					code = $fscanf(fd, " %d", n);
					wait_words(n);
					finish_test($sformatf("run of %0d words", n), errs);
				end
				"X": begin
					clear_done();
					finish_test("clear done", errs);
				end
				"E": begin
					code = $fscanf(fd, " %d", n);
					@(negedge CLK40);
					check_value(32'(wrt_on_rst), 32'(n), "wrt_on_rst");
					finish_test($sformatf("wrt_on_rst is %0d", n), errs);
				end
				default: begin
					$display("Unknown command %c in the test file", cmd);
					n_errors++;
					aborted = 1'b1;
				end
			endcase
		end
		if (fd != 0)
			$fclose(fd);
		// Dropped words would show up here
		check_value(32'(got_q.size()), 32'd0, "unexpected serial words left");
		check_value(32'(exp_q.size()), 32'd0, "words never shifted out");
		$display("%0d tests, %0d errors", n_tests, n_errors);
		if (n_errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

//--- src/al_buckeye_load.sv
module al_buckeye_load import bky_load_pkg::*; (
	input  logic              CLK40,
	input  logic              RST,
	input  logic              slow_fifo_rst,
	input  logic              clr_al_done,
	input  logic              capture,
	input  logic [word_w-1:0] bpi_al_reg,
	output logic              al_bky_ena,
	output logic              shck_ena,
	output logic              sclk,
	output logic              sdata,
	output logic              al_done,
	output logic              al_bk_ld_mt,
	output logic              wrt_on_rst,
	output bky_state_t        al_bk_state
);

	logic              tick;
	logic              word_end;
	logic              rd_en;
	logic              sr_load;
	logic              fifo_empty;
	logic              fifo_full;
	logic [word_w-1:0] fifo_dout;
	logic              cap_ok;

	// Only captures that really land in the FIFO start a run
	assign cap_ok      = capture & ~slow_fifo_rst & ~fifo_full;
	assign al_bk_ld_mt = fifo_empty;

	////////////////////////////////////////////////////////////
	// Blocks
	////////////////////////////////////////////////////////////
	shift_tick_timer u_timer (
		.CLK40, .RST, .shck_ena, .tick, .sclk, .word_end
	);

	bky_load_fsm u_fsm (
		.CLK40, .RST,
		.capture (cap_ok),
		.clr_al_done, .tick, .word_end,
		.empty   (fifo_empty),
		.rd_en,
		.load    (sr_load),
		.shck_ena, .al_bky_ena, .al_done,
		.state   (al_bk_state)
	);

	al_word_fifo u_fifo (
		.CLK40, .RST,
		.clr   (slow_fifo_rst),
		.wr_en (capture),      // FIFO drops it itself while cleared
		.din   (bpi_al_reg),
		.rd_en,
		.dout  (fifo_dout),
		.empty (fifo_empty),
		.full  (fifo_full)
	);

	bky_shift_reg u_sreg (
		.CLK40, .RST, .tick,
		.load (sr_load),
		.shck_ena,
		.din  (fifo_dout),
		.sdata
	);

	// Sticky flag for captures lost to the slow FIFO reset
	always_ff @(posedge CLK40 or posedge RST) begin
		if (RST)
			wrt_on_rst <= 1'b0;
		else if (slow_fifo_rst && capture)
			wrt_on_rst <= 1'b1;
	end

	a_wrt_on_rst_sticky: assert property (@(posedge CLK40)
		$fell(wrt_on_rst) |-> RST);

endmodule

//--- src/bky_shift_reg.sv
module bky_shift_reg import bky_load_pkg::*; (
	input  logic              CLK40,
	input  logic              RST,
	input  logic              tick,
	input  logic              load,
	input  logic              shck_ena,
	input  logic [word_w-1:0] din,
	output logic              sdata
);

	logic [word_w-1:0] sr;

	////////////////////////////////////////////////////////////
	// Load and shift, LSB goes out first
	////////////////////////////////////////////////////////////
	always_ff @(posedge CLK40 or posedge RST) begin
		if (RST) begin
			sr <= '0; // Keeps the serial line low out of reset
		end else if (load) begin
			sr <= din;
		end else if (tick && shck_ena) begin
			sr <= {1'b0, sr[word_w-1:1]}; // Zero fill from the top
		end
	end

	assign sdata = sr[0];

endmodule

//--- src/al_word_fifo.sv
module al_word_fifo import bky_load_pkg::*; (
	input  logic              CLK40,
	input  logic              RST,
	input  logic              clr,
	input  logic              wr_en,
	input  logic [word_w-1:0] din,
	input  logic              rd_en,
	output logic [word_w-1:0] dout,
	output logic              empty,
	output logic              full
);

	logic [word_w-1:0]  mem [fifo_depth];
	logic [fifo_aw-1:0] wr_ptr;
	logic [fifo_aw-1:0] rd_ptr;
	logic [fifo_aw:0]   count;
	logic               wr_ok;
	logic               rd_ok;

	// Slow reset blocks both ports
	assign wr_ok = wr_en & ~full & ~clr;
	assign rd_ok = rd_en & ~empty & ~clr;

	assign empty = (count == '0);
	assign full  = (count == (fifo_aw + 1)'(fifo_depth));

	////////////////////////////////////////////////////////////
	// Pointers and fill level
	////////////////////////////////////////////////////////////
	always_ff @(posedge CLK40 or posedge RST) begin
		if (RST) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else if (clr) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_ok)
				wr_ptr <= wr_ptr + 1'b1; // Depth is a power of two
			if (rd_ok)
				rd_ptr <= rd_ptr + 1'b1;
			case ({wr_ok, rd_ok})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Storage with registered read port
	always_ff @(posedge CLK40) begin
		if (wr_ok)
			mem[wr_ptr] <= din;
		if (rd_ok)
			dout <= mem[rd_ptr];
	end

	// Loader must never pop an empty queue
	a_no_read_empty: assert property (@(posedge CLK40) disable iff (RST)
		rd_en |-> !empty);

endmodule

//--- src/bky_load_fsm.sv
module bky_load_fsm import bky_load_pkg::*; (
	input  logic       CLK40,
	input  logic       RST,
	input  logic       capture,
	input  logic       clr_al_done,
	input  logic       tick,
	input  logic       word_end,
	input  logic       empty,
	output logic       rd_en,
	output logic       load,
	output logic       shck_ena,
	output logic       al_bky_ena,
	output logic       al_done,
	output bky_state_t state
);

	logic set_done;

	// One-cycle strobes, all aligned to tick
	assign rd_en    = tick & (state == read) & ~empty;
	assign load     = tick & (state == bky_load_pkg::load); // Scoped, port has same name
	assign set_done = tick & (state == finish) & empty;

	////////////////////////////////////////////////////////////
	// Load and done flags
	////////////////////////////////////////////////////////////
	always_ff @(posedge CLK40 or posedge RST) begin
		if (RST) begin
			al_bky_ena <= 1'b0;
			al_done    <= 1'b0;
		end else begin
			// A fresh capture wins over the end of a run
			if (capture)
				al_bky_ena <= 1'b1;
			else if (set_done)
				al_bky_ena <= 1'b0;

			if (clr_al_done)
				al_done <= 1'b0;
			else if (set_done)
				al_done <= 1'b1; // Held until software clears it
		end
	end

	////////////////////////////////////////////////////////////
	// Sequencer, advances only on ticks
	////////////////////////////////////////////////////////////
	always_ff @(posedge CLK40 or posedge RST) begin
		if (RST) begin
			state    <= idle;
			shck_ena <= 1'b0;
		end else if (tick) begin
			case (state)
				idle: begin
					if (al_bky_ena && !empty)
						state <= read;
					else if (al_bky_ena)
						state <= finish; // Nothing was queued
				end
				read: begin
					if (empty)
						state <= finish;
					else
						state <= bky_load_pkg::load; // dout valid next cycle
				end
				bky_load_pkg::load: begin
					state    <= shift;
					shck_ena <= 1'b1;
				end
				shift: begin
					if (word_end) begin
						shck_ena <= 1'b0;
						state    <= empty ? finish : read;
					end
				end
				finish: begin
					// Late capture keeps the run going
					state <= empty ? idle : read;
				end
				default: state <= idle;
			endcase
		end
	end

	// Shift clock window matches the shift state
	a_shck_in_shift: assert property (@(posedge CLK40) disable iff (RST)
		shck_ena |-> state == shift);

endmodule

//--- src/shift_tick_timer.sv
module shift_tick_timer import bky_load_pkg::*; (
	input  logic CLK40,
	input  logic RST,
	input  logic shck_ena,
	output logic tick,
	output logic sclk,
	output logic word_end
);

	logic [tick_cnt_w-1:0] cyc_cnt;
	logic [bit_cnt_w-1:0]  bit_cnt;

	////////////////////////////////////////////////////////////
	// Bit period divider
	////////////////////////////////////////////////////////////
	always_ff @(posedge CLK40 or posedge RST) begin
		if (RST)
			cyc_cnt <= '0;
		else if (tick)
			cyc_cnt <= '0;
		else
			cyc_cnt <= cyc_cnt + 1'b1;
	end

	assign tick = (cyc_cnt == tick_cnt_w'(tick_div - 1)); // Last cycle of the bit

	// Low in first half of the bit, high in second half
	assign sclk = shck_ena & (cyc_cnt >= tick_cnt_w'(tick_div / 2));

	////////////////////////////////////////////////////////////
	// Bit position within the word being shifted
	////////////////////////////////////////////////////////////
	always_ff @(posedge CLK40 or posedge RST) begin
		if (RST)
			bit_cnt <= '0;
		else if (tick && shck_ena)
			bit_cnt <= bit_cnt + 1'b1; // Wraps back to 0 after the last bit
	end

	assign word_end = tick & shck_ena & (bit_cnt == bit_cnt_w'(word_w - 1));

	// Ticks are isolated pulses
	a_tick_single: assert property (@(posedge CLK40) disable iff (RST)
		tick |=> !tick);

endmodule

//--- src/bky_load_pkg.sv
package bky_load_pkg;

	////////////////////////////////////////////////////////////
	// Word and FIFO geometry
	////////////////////////////////////////////////////////////
	localparam int word_w     = 16;  // One configuration word
	localparam int fifo_depth = 64;
	localparam int fifo_aw    = 6;   // log2 of fifo_depth

	////////////////////////////////////////////////////////////
	// Serial shift timing
	////////////////////////////////////////////////////////////
	localparam int tick_div   = 40;  // CLK40 cycles per serial bit
	localparam int tick_cnt_w = 6;   // Holds 0 .. tick_div-1
	localparam int bit_cnt_w  = 4;   // Bit index within a word

	// Loader states
	typedef enum logic [2:0] {
		idle   = 3'd0,
		read   = 3'd1,
		load   = 3'd2,
		shift  = 3'd3,
		finish = 3'd4
	} bky_state_t;

endpackage
